// File: logic/rvArithPkg.sv
package rvArithPkg;

   // Data path width, the whole design is built for 32 bits
   localparam int XLEN = 32;

   // Only the low five bits of operand B count as shift amount
   localparam int SHIFT_BITS = 5;

   // Restoring divider makes one quotient bit per step
   localparam int DIV_STEPS = 32;

   // Operand and result word
   typedef logic [XLEN-1:0] word_t;

   // Operation code seen by the whole unit
   // Base ALU ops come first, M extension from OP_MUL on
   typedef enum logic [4:0] {
      OP_ADD    = 5'd0,   // A + B
      OP_SUB    = 5'd1,   // A - B
      OP_SLL    = 5'd2,   // Shift left logical
      OP_SLT    = 5'd3,   // Signed less-than
      OP_SLTU   = 5'd4,   // Unsigned less-than
      OP_XOR    = 5'd5,
      OP_SRL    = 5'd6,   // Shift right logical
      OP_SRA    = 5'd7,   // Shift right arithmetic
      OP_OR     = 5'd8,
      OP_AND    = 5'd9,

      // Multiplies
      OP_MUL    = 5'd10,  // Low word of product
      OP_MULH   = 5'd11,  // High word, signed x signed
      OP_MULHSU = 5'd12,  // High word, signed x unsigned
      OP_MULHU  = 5'd13,  // High word, unsigned x unsigned

      // Divides and remainders
      OP_DIV    = 5'd14,
      OP_DIVU   = 5'd15,
      OP_REM    = 5'd16,
      OP_REMU   = 5'd17
   } arithOp_t;

endpackage

// File: logic/intAlu.sv
`timescale 1ns/10ps

module intAlu (
   input  rvArithPkg::arithOp_t op,
   input  rvArithPkg::word_t    operandA,
   input  rvArithPkg::word_t    operandB,
   output rvArithPkg::word_t    aluResult
);
   import rvArithPkg::*;

   // Bit reversal so the right shifter also does left shifts
   function automatic word_t flipWord(input word_t x);
      word_t y;
      for (int i = 0; i < XLEN; i++) begin
         y[i] = x[XLEN-1-i];
      end
      return y;
   endfunction

   logic isAdd;
   logic isSub;
   logic isSll;
   logic isSlt;
   logic isSltu;
   logic isXor;
   logic isSrl;
   logic isSra;
   logic isOr;
   logic isAnd;

   word_t              aluPlus;
   logic [XLEN:0]      aluMinus;    // Bit XLEN is the borrow
   logic               lessSigned;
   logic               lessUnsigned;
   word_t              shifterIn;
   logic signed [XLEN:0] shiftWide;
   word_t              shifter;
   word_t              leftShift;

   // One-hot decode of the base ops, M ops leave all of these low
   assign isAdd  = (op == OP_ADD);
   assign isSub  = (op == OP_SUB);
   assign isSll  = (op == OP_SLL);
   assign isSlt  = (op == OP_SLT);
   assign isSltu = (op == OP_SLTU);
   assign isXor  = (op == OP_XOR);
   assign isSrl  = (op == OP_SRL);
   assign isSra  = (op == OP_SRA);
   assign isOr   = (op == OP_OR);
   assign isAnd  = (op == OP_AND);

   assign aluPlus = operandA + operandB;

   // A + ~B + 1 over 33 bits, top bit set when A < B unsigned
   assign aluMinus = {1'b1, ~operandB} + {1'b0, operandA} + {{XLEN{1'b0}}, 1'b1};

   assign lessUnsigned = aluMinus[XLEN];
   // Differing signs decide on their own
   assign lessSigned   = (operandA[XLEN-1] ^ operandB[XLEN-1]) ? operandA[XLEN-1]
                                                                : aluMinus[XLEN];

   // Single arithmetic shifter, fill bit is the sign only for SRA
   assign shifterIn = isSll ? flipWord(operandA) : operandA;
   assign shiftWide = $signed({isSra & operandA[XLEN-1], shifterIn})
                      >>> operandB[SHIFT_BITS-1:0];
   assign shifter   = shiftWide[XLEN-1:0];   // Fill bit dropped
   assign leftShift = flipWord(shifter);

   // OR of gated terms, exactly one term is live per base op
   assign aluResult =
      (isAdd  ? aluPlus                           : '0) |
      (isSub  ? aluMinus[XLEN-1:0]                : '0) |
      (isSll  ? leftShift                         : '0) |
      (isSlt  ? {{(XLEN-1){1'b0}}, lessSigned}    : '0) |
      (isSltu ? {{(XLEN-1){1'b0}}, lessUnsigned}  : '0) |
      (isXor  ? operandA ^ operandB               : '0) |
      (isSrl  ? shifter                           : '0) |
      (isSra  ? shifter                           : '0) |
      (isOr   ? operandA | operandB               : '0) |
      (isAnd  ? operandA & operandB               : '0);

endmodule

// File: logic/mulDivUnit.sv
`timescale 1ns/10ps

module mulDivUnit (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  rvArithPkg::arithOp_t op,
   input  rvArithPkg::word_t    operandA,
   input  rvArithPkg::word_t    operandB,
   output logic                 done,
   output rvArithPkg::word_t    mdResult
);
   import rvArithPkg::*;

   typedef enum logic [1:0] {
      PH_IDLE,   // Waiting for start
      PH_MUL,    // Product is registered, result out
      PH_STEP,   // Shift and subtract steps
      PH_FIX     // Sign correction, result out
   } mdPhase_t;

   mdPhase_t phase;
   logic     busy;
   logic     launch;

   logic [$clog2(DIV_STEPS+1)-1:0] stepCount;   // Steps left

   logic isMul;
   logic isUnsignedDiv;
   logic isRem;

   // Multiplier
   logic                     signA;
   logic                     signB;
   logic signed [XLEN:0]     mulInA;
   logic signed [XLEN:0]     mulInB;
   logic signed [2*XLEN+1:0] product;
   word_t                    mulResult;

   // Divider
   word_t             absA;
   word_t             absB;
   word_t             remReg;        // Running dividend, ends as remainder
   logic [2*XLEN-2:0] divisorReg;    // Divisor aligned under the dividend
   word_t             quotientReg;
   logic              negResult;     // Final result needs negation
   logic              fits;
   word_t             divOut;

   assign busy   = (phase != PH_IDLE);
   assign launch = start && !busy;   // Start ignored while busy

   assign isMul         = op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
   assign isUnsignedDiv = op inside {OP_DIVU, OP_REMU};
   assign isRem         = op inside {OP_REM, OP_REMU};

   // One 33x33 signed multiply, extension bit picks signedness
   assign signA   = operandA[XLEN-1] & (op == OP_MULH || op == OP_MULHSU);
   assign signB   = operandB[XLEN-1] & (op == OP_MULH);
   assign mulInA  = {signA, operandA};
   assign mulInB  = {signB, operandB};
   assign product = mulInA * mulInB;

   always_ff @(posedge clk) begin
      if (launch) begin
         mulResult <= (op == OP_MUL) ? product[XLEN-1:0]       // Low word
                                     : product[2*XLEN-1:XLEN]; // High word
      end
   end

   // Divider works on magnitudes
   assign absA = (!isUnsignedDiv && operandA[XLEN-1]) ? -operandA : operandA;
   assign absB = (!isUnsignedDiv && operandB[XLEN-1]) ? -operandB : operandB;

   assign fits = (divisorReg <= {{(XLEN-1){1'b0}}, remReg});

   always_ff @(posedge clk) begin
      if (launch) begin
         // Quotient sign only for a nonzero divisor, so x/0 stays all ones
         negResult   <= !isUnsignedDiv &&
                        (isRem ? operandA[XLEN-1]
                               : (operandA[XLEN-1] ^ operandB[XLEN-1]) && |operandB);
         remReg      <= absA;
         divisorReg  <= {absB, {(XLEN-1){1'b0}}};
         quotientReg <= '0;
      end else if (phase == PH_STEP) begin
         divisorReg <= divisorReg >> 1;
         if (fits) begin
            quotientReg <= {quotientReg[XLEN-2:0], 1'b1};
            remReg      <= remReg - divisorReg[XLEN-1:0];
         end else begin
            quotientReg <= {quotientReg[XLEN-2:0], 1'b0};
         end
      end
   end

   // Phase sequencing
   always_ff @(posedge clk) begin
      if (!reset) begin
         phase     <= PH_IDLE;
         stepCount <= '0;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (launch) begin
                  if (isMul) begin
                     phase <= PH_MUL;
                  end else begin
                     phase     <= PH_STEP;
                     stepCount <= $bits(stepCount)'(DIV_STEPS);
                  end
               end
            end
            PH_STEP: begin
               stepCount <= stepCount - $bits(stepCount)'(1);
               if (stepCount == $bits(stepCount)'(1)) begin
                  phase <= PH_FIX;   // Last step done
               end
            end
            default: phase <= PH_IDLE;   // MUL and FIX last one cycle
         endcase
      end
   end

   // Sign fix in the final cycle
   assign divOut = isRem ? (negResult ? -remReg : remReg)
                         : (negResult ? -quotientReg : quotientReg);

   assign done     = (phase == PH_MUL) || (phase == PH_FIX);
   assign mdResult = (phase == PH_MUL) ? mulResult : divOut;

endmodule

// File: logic/arithControl.sv
`timescale 1ns/10ps

module arithControl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   output logic                 ack,
   input  rvArithPkg::arithOp_t op,
   input  rvArithPkg::word_t    aluResult,
   input  rvArithPkg::word_t    mdResult,
   input  logic                 done,
   output logic                 start,
   output rvArithPkg::word_t    result
);
   import rvArithPkg::*;

   typedef enum logic [1:0] {
      IDLE,           // Ready for a request
      WAIT_MD,        // Multiply or divide running
      HOLD_ACK,       // Ack high until req drops
      WAIT_REQ_LOW    // Out of reset, req must be seen low first
   } ctrlState_t;

   ctrlState_t state;
   logic       isMdOp;
   logic       takeAlu;
   logic       takeMd;

   // Opcode class is decided here only
   assign isMdOp = op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                              OP_DIV, OP_DIVU, OP_REM, OP_REMU};

   assign takeAlu = (state == IDLE) && req && !isMdOp;   // Same-cycle capture
   assign takeMd  = (state == WAIT_MD) && done;

   // Single-cycle pulse, IDLE is left on the next edge
   assign start = (state == IDLE) && req && isMdOp;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= WAIT_REQ_LOW;   // A request left over from before reset is skipped
         ack   <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (takeAlu) begin
                  state <= HOLD_ACK;
                  ack   <= 1'b1;
               end else if (start) begin
                  state <= WAIT_MD;
               end
            end
            WAIT_MD: begin
               if (takeMd) begin
                  state <= HOLD_ACK;
                  ack   <= 1'b1;
               end
            end
            HOLD_ACK: begin
               if (!req) begin
                  state <= IDLE;
                  ack   <= 1'b0;   // Falls one cycle after req
               end
            end
            WAIT_REQ_LOW: begin
               if (!req) state <= IDLE;
            end
         endcase
      end
   end

   // Result loads on the edge that raises ack, then holds
   always_ff @(posedge clk) begin
      if (takeAlu) begin
         result <= aluResult;
      end else if (takeMd) begin
         result <= mdResult;
      end
   end

endmodule

// File: logic/rvArithUnit.sv
`timescale 1ns/10ps

module rvArithUnit (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   output logic                 ack,
   input  rvArithPkg::arithOp_t op,
   input  rvArithPkg::word_t    operandA,
   input  rvArithPkg::word_t    operandB,
   output rvArithPkg::word_t    result
);
   import rvArithPkg::*;

   word_t aluResult;   // Combinational base ALU result
   word_t mdResult;    // Valid while mdDone is high
   logic  mdStart;
   logic  mdDone;

   // Handshake and result capture
   arithControl i_arithControl (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .ack       (ack),
      .op        (op),
      .aluResult (aluResult),
      .mdResult  (mdResult),
      .done      (mdDone),
      .start     (mdStart),
      .result    (result)
   );

   // Always evaluating the current operands
   intAlu i_intAlu (
      .op        (op),
      .operandA  (operandA),
      .operandB  (operandB),
      .aluResult (aluResult)
   );

   mulDivUnit i_mulDivUnit (
      .clk       (clk),
      .reset     (reset),
      .start     (mdStart),
      .op        (op),
      .operandA  (operandA),
      .operandB  (operandB),
      .done      (mdDone),
      .mdResult  (mdResult)
   );

endmodule

// File: dv/clockGen.sv
`timescale 1ns/10ps

module clockGen (
   output logic clk,
   output logic reset
);
   localparam int HALF_PERIOD  = 5;   // 10 ns clock
   localparam int RESET_CYCLES = 5;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Active low, released on a rising edge
   initial begin
      reset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b1;
   end
endmodule

// File: dv/rvArith_checker.sv
`timescale 1ns/10ps

module rvArith_checker (
   input logic              clk,
   input logic              reset,
   input logic              req,
   input logic              ack,
   input rvArithPkg::word_t result
);
   import rvArithPkg::*;

   // Divide is the longest op, plus handshake cycles
   localparam int MAX_LATENCY = DIV_STEPS + 4;

   int errorCount = 0;   // Failed assertions so far

   ackNeedsReq: assert property (@(posedge clk) disable iff (!reset)
      $rose(ack) |-> $past(req))
      else begin
         errorCount++;
         $error("ack rose without a request");
      end

   // Result frozen for the whole ack phase
   resultHeld: assert property (@(posedge clk) disable iff (!reset)
      (ack && $past(ack)) |-> $stable(result))
      else begin
         errorCount++;
         $error("result changed while ack was high");
      end

   ackFallsAfterReq: assert property (@(posedge clk) disable iff (!reset)
      $fell(ack) |-> $past(!req))
      else begin
         errorCount++;
         $error("ack fell while req was still high");
      end

   ackLowInReset: assert property (@(posedge clk)
      !reset |=> !ack)
      else begin
         errorCount++;
         $error("ack high during reset");
      end

   reqAnswered: assert property (@(posedge clk) disable iff (!reset)
      $rose(req) |-> ##[1:MAX_LATENCY] ack)
      else begin
         errorCount++;
         $error("request not answered in time");
      end
endmodule

// File: dv/rvArithTb.sv
`timescale 1ns/10ps

module rvArithTb;
   import rvArithPkg::*;

   localparam int TIMEOUT_CYCLES = 100;
   localparam int RAND_SEED      = 84815;
   localparam int NUM_RANDOM     = 200;
   localparam int HOLD_CYCLES    = 20;

   logic     clk;
   logic     reset;
   logic     req;
   logic     ack;
   arithOp_t op;
   word_t    operandA;
   word_t    operandB;
   word_t    result;

   int          mismatchCount = 0;
   int          timeoutCount  = 0;
   int          protocolCount = 0;
   int          checkCount    = 0;
   logic        aborted       = 1'b0;   // Set on a timeout, later requests skipped

   clockGen i_clockGen (.clk(clk), .reset(reset));

   rvArithUnit i_rvArithUnit (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .ack      (ack),
      .op       (op),
      .operandA (operandA),
      .operandB (operandB),
      .result   (result)
   );

   bind rvArithUnit rvArith_checker i_rvArith_checker (
      .clk(clk), .reset(reset), .req(req), .ack(ack), .result(result));

   // Reference model built from the RV32IM rules
   function automatic word_t expectedResult(input arithOp_t opIn, input word_t a, input word_t b);
      logic signed [2*XLEN-1:0] prodSS;   // Signed x signed
      logic signed [2*XLEN-1:0] prodSU;   // Signed x unsigned
      logic [2*XLEN-1:0]        prodUU;   // Unsigned x unsigned
      logic [SHIFT_BITS-1:0]    shamt;
      logic                     overflow;
      shamt    = b[SHIFT_BITS-1:0];
      overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);   // Most negative / -1
      prodSS   = $signed(a) * $signed(b);
      prodSU   = $signed(a) * $signed({1'b0, b});
      prodUU   = a * b;
      case (opIn)
         OP_ADD:    return a + b;
         OP_SUB:    return a - b;
         OP_SLL:    return a << shamt;
         OP_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLTU:   return (a < b) ? 32'd1 : 32'd0;
         OP_XOR:    return a ^ b;
         OP_SRL:    return a >> shamt;
         OP_SRA:    return word_t'($signed(a) >>> shamt);
         OP_OR:     return a | b;
         OP_AND:    return a & b;
         OP_MUL:    return prodUU[XLEN-1:0];
         OP_MULH:   return prodSS[2*XLEN-1:XLEN];
         OP_MULHSU: return prodSU[2*XLEN-1:XLEN];
         OP_MULHU:  return prodUU[2*XLEN-1:XLEN];
         OP_DIV:    return (b == 0) ? '1 : overflow ? a : word_t'($signed(a) / $signed(b));
         OP_DIVU:   return (b == 0) ? '1 : a / b;
         OP_REM:    return (b == 0) ? a : overflow ? '0 : word_t'($signed(a) % $signed(b));
         OP_REMU:   return (b == 0) ? a : a % b;
         default:   return '0;
      endcase
   endfunction

   task automatic checkWord(input string what, input word_t got, input word_t exp);
      checkCount++;
      if (got !== exp) begin
         mismatchCount++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Sampled on falling edges, cycles counts edges before ack reached level
   task automatic waitForAck(input logic level, output int cycles);
      cycles = 0;
      @(negedge clk);
      while (ack !== level && cycles < TIMEOUT_CYCLES) begin
         cycles++;
         @(negedge clk);
      end
      if (ack !== level) begin
         timeoutCount++;
         aborted = 1'b1;
         $display("Timeout at %0t: ack did not go %s within %0d cycles", $time,
                  level ? "high" : "low", TIMEOUT_CYCLES);
      end
   endtask

   // Full four-phase transfer, latency checked when expLatency >= 0
   task automatic runOp(input arithOp_t opIn, input word_t a, input word_t b, input int expLatency);
      int    cycles;
      string what;
      if (aborted) return;
      what = $sformatf("%s %h,%h", opIn.name(), a, b);
      @(posedge clk);
      op       <= opIn;
      operandA <= a;
      operandB <= b;
      req      <= 1'b1;
      waitForAck(1'b1, cycles);
      if (aborted) return;
      checkWord(what, result, expectedResult(opIn, a, b));
      if (expLatency >= 0) checkWord({what, " ack latency"}, word_t'(cycles), word_t'(expLatency));
      @(posedge clk);
      req <= 1'b0;
      waitForAck(1'b0, cycles);
      if (!aborted) checkWord({what, " ack release"}, word_t'(cycles), 32'd1);
   endtask

   task automatic testBaseAlu();
      int amounts[3] = '{0, 1, 31};
      runOp(OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 1);
      runOp(OP_ADD, 32'hFFFF_FFFF, 32'h0000_0002, 1);   // Carry out dropped
      runOp(OP_SUB, 32'h0000_0000, 32'h0000_0001, 1);
      runOp(OP_SUB, 32'h8000_0000, 32'h0000_0001, 1);
      foreach (amounts[i]) begin
         // Upper bits of B must not change the shift
         runOp(OP_SLL, 32'h8765_4321, 32'hFFFF_FFE0 | amounts[i], 1);
         runOp(OP_SRL, 32'h8765_4321, word_t'(amounts[i]), 1);
         runOp(OP_SRA, 32'h8765_4321, word_t'(amounts[i]), 1);
         runOp(OP_SRA, 32'h4765_4321, word_t'(amounts[i]), 1);
      end
      runOp(OP_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 1);
      runOp(OP_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 1);
      runOp(OP_SLT,  32'h7FFF_FFFF, 32'h8000_0000, 1);
      runOp(OP_SLTU, 32'h7FFF_FFFF, 32'h8000_0000, 1);
      runOp(OP_SLT,  32'h0000_0005, 32'h0000_0005, 1);
      runOp(OP_XOR,  32'hF0F0_1234, 32'h0FF0_FF00, 1);
      runOp(OP_OR,   32'hF0F0_1234, 32'h0FF0_FF00, 1);
      runOp(OP_AND,  32'hF0F0_1234, 32'h0FF0_FF00, 1);
   endtask

   task automatic testMultiply();
      word_t    vals[4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'h7FFF_FFFF};
      arithOp_t ops[4]  = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
      foreach (ops[k]) foreach (vals[i]) foreach (vals[j]) runOp(ops[k], vals[i], vals[j], -1);
   endtask

   // Zero divisor and most negative / -1 are in the operand set
   task automatic testDivide();
      word_t    vals[6] = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7, 32'hFFFF_FFF9};
      arithOp_t ops[4]  = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
      foreach (ops[k]) foreach (vals[i]) foreach (vals[j]) runOp(ops[k], vals[i], vals[j], -1);
   endtask

   task automatic testRandom();
      arithOp_t opIn;
      word_t    a;
      word_t    b;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         opIn = arithOp_t'($urandom_range(17, 0));
         a    = $urandom;
         b    = $urandom;
         if ($urandom_range(7, 0) == 0) b = '0;   // Some divides by zero
         runOp(opIn, a, b, (opIn < OP_MUL) ? 1 : -1);
      end
   endtask

   // Req held long after ack, result must not move
   task automatic testBackPressure();
      word_t held;
      int    cycles;
      if (aborted) return;
      @(posedge clk);
      op       <= OP_DIV;
      operandA <= 32'hFFFF_FF9C;   // -100
      operandB <= 32'h0000_0007;
      req      <= 1'b1;
      waitForAck(1'b1, cycles);
      if (aborted) return;
      held = result;
      checkWord("held DIV", held, expectedResult(OP_DIV, 32'hFFFF_FF9C, 32'h0000_0007));
      for (int i = 0; i < HOLD_CYCLES; i++) begin
         @(negedge clk);
         if (ack !== 1'b1) begin
            protocolCount++;
            $display("At %0t ack dropped while req was still high", $time);
         end
         checkWord("held result", result, held);
      end
      @(posedge clk);
      req <= 1'b0;
      waitForAck(1'b0, cycles);
      runOp(OP_SUB, 32'h0000_0010, 32'h0000_0020, 1);
   endtask

   initial begin
      int waitCount;
      int assertCount;
      void'($urandom(RAND_SEED));
      req      <= 1'b0;
      op       <= OP_ADD;
      operandA <= '0;
      operandB <= '0;
      waitCount = 0;
      while (reset !== 1'b1 && waitCount < TIMEOUT_CYCLES) begin
         @(posedge clk);
         waitCount++;
      end
      if (reset !== 1'b1) begin
         timeoutCount++;
         aborted = 1'b1;
         $display("Timeout: reset was never released");
      end
      repeat (2) @(posedge clk);   // Control leaves its post-reset state
      testBaseAlu();
      testMultiply();
      testDivide();
      testRandom();
      testBackPressure();
      assertCount = i_rvArithUnit.i_rvArith_checker.errorCount;
      $display("Checks %0d, mismatches %0d, timeouts %0d, protocol %0d, assertions %0d",
               checkCount, mismatchCount, timeoutCount, protocolCount, assertCount);
      if (mismatchCount + timeoutCount + protocolCount + assertCount == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end
endmodule

// File: compile.f
logic/rvArithPkg.sv
logic/intAlu.sv
logic/mulDivUnit.sv
logic/arithControl.sv
logic/rvArithUnit.sv
dv/clockGen.sv
dv/rvArith_checker.sv
dv/rvArithTb.sv
